// ==== logic/layers_pkg.sv ====
package layers_pkg;

    // datapath sizes
    localparam int DEPTH_NB  = 2;
    localparam int GROUP_NB  = 2;
    localparam int IMG_WIDTH = 8;
    localparam int KER_WIDTH = 8;
    localparam int ACC_WIDTH = 24;

    // configuration port
    localparam int CFG_DWIDTH      = 32;
    localparam int CFG_AWIDTH      = 5;
    localparam int CFG_LAYERS_ADDR = 3;

    // field positions inside the configuration word
    localparam int CFG_BYPASS_BIT  = 16;
    localparam int CFG_POOL_LSB    = 8;
    localparam int CFG_POOL_WIDTH  = 8;
    localparam int CFG_SHIFT_LSB   = 0;
    localparam int CFG_SHIFT_WIDTH = 8;

    typedef logic signed [IMG_WIDTH-1:0] pixel_t;
    typedef logic signed [KER_WIDTH-1:0] weight_t;
    typedef logic signed [ACC_WIDTH-1:0] acc_t;
    typedef logic [CFG_DWIDTH-1:0]       cfg_data_t;
    typedef logic [CFG_AWIDTH-1:0]       cfg_addr_t;

    typedef struct packed {
        pixel_t [GROUP_NB-1:0] pix;
    } image_beat_t;

    // one weight per depth and group lane
    typedef struct packed {
        weight_t [DEPTH_NB-1:0][GROUP_NB-1:0] w;
    } kernel_set_t;

    typedef weight_t [DEPTH_NB-1:0] bias_set_t;
    typedef acc_t [DEPTH_NB-1:0]    depth_acc_t;
    typedef pixel_t [DEPTH_NB-1:0]  result_bus_t;

    typedef struct packed {
        logic                       bypass;
        logic [CFG_POOL_WIDTH-1:0]  pool_nb;
        logic [CFG_SHIFT_WIDTH-1:0] shift;
    } layer_cfg_t;

    typedef enum logic [1:0] {UP_RESET, UP_READY, UP_DONE} up_state_t;
    typedef enum logic [1:0] {POOL_IDLE, POOL_SUM, POOL_HOLD} pool_state_t;

endpackage

// ==== logic/layer_decode.sv ====
`timescale 1ns/10ps

module layer_decode
    import layers_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  cfg_data_t   cfg_data,
    input  cfg_addr_t   cfg_addr,
    input  logic        cfg_valid,

    input  image_beat_t image_bus,
    input  logic        image_last,
    input  logic        image_val,
    output logic        image_rdy,
    output logic        kernel_rdy,

    input  logic        window_done,

    output layer_cfg_t  cfg,
    output logic        mac_valid,
    output image_beat_t mac_beat,
    output logic        mac_clear,
    output logic        window_end
);

    up_state_t up_state;
    up_state_t up_state_nx;

    logic accept;
    logic window_open;
    logic last_beat;

    // configuration register, written only at its own address
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
        end else if (cfg_valid && (cfg_addr == cfg_addr_t'(CFG_LAYERS_ADDR))) begin
            cfg.bypass  <= cfg_data[CFG_BYPASS_BIT];
            cfg.pool_nb <= cfg_data[CFG_POOL_LSB +: CFG_POOL_WIDTH];
            cfg.shift   <= cfg_data[CFG_SHIFT_LSB +: CFG_SHIFT_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            up_state <= UP_RESET;
        end else begin
            up_state <= up_state_nx;
        end
    end

    always_comb begin
        up_state_nx = up_state;
        case (up_state)
            UP_RESET: up_state_nx = UP_READY;
            UP_READY: begin
                if (accept && image_last) begin
                    up_state_nx = UP_DONE;
                end
            end
            // wait for execute to finish the window
            UP_DONE: begin
                if (window_done) begin
                    up_state_nx = UP_READY;
                end
            end
            default: up_state_nx = UP_RESET;
        endcase
    end

    assign image_rdy = (up_state == UP_READY);
    assign accept    = image_val && image_rdy;

    // first beat of a window is the first one taken after leaving reset or done
    always_ff @(posedge clk) begin
        if (rst) begin
            window_open <= 1'b0;
        end else if (up_state != UP_READY) begin
            window_open <= 1'b0;
        end else if (accept) begin
            window_open <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            kernel_rdy <= 1'b0;
            mac_clear  <= 1'b0;
            last_beat  <= 1'b0;
            window_end <= 1'b0;
        end else begin
            kernel_rdy <= accept;
            mac_clear  <= accept && !window_open;
            last_beat  <= accept && image_last;
            // accumulators hold the final value one cycle after the last mac
            window_end <= last_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mac_beat <= image_bus;
        end
    end

    // kernel words arrive with kernel_rdy, so the mac runs in that cycle
    assign mac_valid = kernel_rdy;

endmodule

// ==== logic/layer_execute.sv ====
`timescale 1ns/10ps

module layer_execute
    import layers_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  layer_cfg_t  cfg,
    input  logic        mac_valid,
    input  image_beat_t mac_beat,
    input  logic        mac_clear,
    input  logic        window_end,
    input  kernel_set_t kernel_bus,

    input  logic        result_idle,
    output logic        window_done,
    output logic        pool_valid,
    output depth_acc_t  pool_data
);

    pool_state_t pool_state;

    logic [CFG_POOL_WIDTH-1:0] pool_cnt;
    logic                      pool_last;

    acc_t [DEPTH_NB-1:0][GROUP_NB-1:0] prod;
    acc_t [DEPTH_NB-1:0][GROUP_NB-1:0] acc_q;

    depth_acc_t lane_sum;
    depth_acc_t sum_q;

    // products sign extended to accumulator width
    always_comb begin
        for (int d = 0; d < DEPTH_NB; d++) begin
            for (int g = 0; g < GROUP_NB; g++) begin
                prod[d][g] = acc_t'($signed(mac_beat.pix[g]) * $signed(kernel_bus.w[d][g]));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mac_valid) begin
            for (int d = 0; d < DEPTH_NB; d++) begin
                for (int g = 0; g < GROUP_NB; g++) begin
                    if (mac_clear) begin
                        acc_q[d][g] <= prod[d][g];
                    end else begin
                        acc_q[d][g] <= acc_q[d][g] + prod[d][g];
                    end
                end
            end
        end
    end

    always_comb begin
        for (int d = 0; d < DEPTH_NB; d++) begin
            lane_sum[d] = '0;
            for (int g = 0; g < GROUP_NB; g++) begin
                lane_sum[d] = lane_sum[d] + acc_q[d][g];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (window_end) begin
            sum_q <= lane_sum;
        end
    end

    assign pool_last = (pool_cnt == cfg.pool_nb);

    // running maximum, the first window of a frame overwrites it
    always_ff @(posedge clk) begin
        if (pool_state == POOL_SUM) begin
            for (int d = 0; d < DEPTH_NB; d++) begin
                if ((pool_cnt == '0) || ($signed(sum_q[d]) > $signed(pool_data[d]))) begin
                    pool_data[d] <= sum_q[d];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pool_state  <= POOL_IDLE;
            pool_cnt    <= '0;
            window_done <= 1'b0;
            pool_valid  <= 1'b0;
        end else begin
            window_done <= 1'b0;
            pool_valid  <= 1'b0;
            case (pool_state)
                POOL_IDLE: begin
                    if (window_end) begin
                        pool_state <= POOL_SUM;
                    end
                end
                POOL_SUM: begin
                    if (pool_last) begin
                        pool_cnt   <= '0;
                        pool_state <= POOL_HOLD;
                    end else begin
                        pool_cnt    <= pool_cnt + 1'b1;
                        window_done <= 1'b1;
                        pool_state  <= POOL_IDLE;
                    end
                end
                // the result path still holds the previous frame
                POOL_HOLD: begin
                    if (result_idle) begin
                        pool_valid  <= 1'b1;
                        window_done <= 1'b1;
                        pool_state  <= POOL_IDLE;
                    end
                end
                default: pool_state <= POOL_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/layer_result.sv ====
`timescale 1ns/10ps

module layer_result
    import layers_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  layer_cfg_t  cfg,
    input  logic        pool_valid,
    input  depth_acc_t  pool_data,
    input  bias_set_t   bias_bus,

    output result_bus_t result_bus,
    output logic        result_val,
    input  logic        result_rdy,
    output logic        result_idle
);

    depth_acc_t bias_q;
    depth_acc_t relu_q;
    logic       bias_valid;
    logic       relu_valid;
    logic       busy;

    // arithmetic shift, then clamp into the pixel range
    function automatic pixel_t rescale(acc_t value, logic [CFG_SHIFT_WIDTH-1:0] shift);
        acc_t shifted;
        logic [ACC_WIDTH-IMG_WIDTH:0] upper;
        begin
            shifted = value >>> shift;
            upper   = shifted[ACC_WIDTH-1:IMG_WIDTH-1];
            if ((&upper) || !(|upper)) begin
                rescale = shifted[IMG_WIDTH-1:0];
            end else if (shifted[ACC_WIDTH-1]) begin
                rescale = {1'b1, {(IMG_WIDTH-1){1'b0}}};
            end else begin
                rescale = {1'b0, {(IMG_WIDTH-1){1'b1}}};
            end
        end
    endfunction

    always_ff @(posedge clk) begin
        for (int d = 0; d < DEPTH_NB; d++) begin
            if (pool_valid) begin
                bias_q[d] <= pool_data[d] + acc_t'($signed(bias_bus[d]));
            end
            if (bias_valid) begin
                // negative values clamp to zero unless bypassed
                relu_q[d] <= (!cfg.bypass && bias_q[d][ACC_WIDTH-1]) ? '0 : bias_q[d];
            end
            if (relu_valid) begin
                result_bus[d] <= rescale(relu_q[d], cfg.shift);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bias_valid <= 1'b0;
            relu_valid <= 1'b0;
            result_val <= 1'b0;
            busy       <= 1'b0;
        end else begin
            bias_valid <= pool_valid;
            relu_valid <= bias_valid;
            if (relu_valid) begin
                result_val <= 1'b1;
            end else if (result_rdy) begin
                result_val <= 1'b0;
            end
            if (pool_valid) begin
                busy <= 1'b1;
            end else if (result_val && result_rdy) begin
                busy <= 1'b0;
            end
        end
    end

    assign result_idle = !(busy || pool_valid);

endmodule

// ==== logic/layers.sv ====
`timescale 1ns/10ps

module layers
    import layers_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  cfg_data_t   cfg_data,
    input  cfg_addr_t   cfg_addr,
    input  logic        cfg_valid,

    input  image_beat_t image_bus,
    input  logic        image_last,
    input  logic        image_val,
    output logic        image_rdy,

    input  kernel_set_t kernel_bus,
    input  bias_set_t   bias_bus,
    output logic        kernel_rdy,

    output result_bus_t result_bus,
    output logic        result_val,
    input  logic        result_rdy
);

    layer_cfg_t  cfg;
    logic        mac_valid;
    image_beat_t mac_beat;
    logic        mac_clear;
    logic        window_end;
    logic        window_done;
    logic        pool_valid;
    depth_acc_t  pool_data;
    logic        result_idle;

    layer_decode decode_inst (
        .clk         (clk),
        .rst         (rst),
        .cfg_data    (cfg_data),
        .cfg_addr    (cfg_addr),
        .cfg_valid   (cfg_valid),
        .image_bus   (image_bus),
        .image_last  (image_last),
        .image_val   (image_val),
        .image_rdy   (image_rdy),
        .kernel_rdy  (kernel_rdy),
        .window_done (window_done),
        .cfg         (cfg),
        .mac_valid   (mac_valid),
        .mac_beat    (mac_beat),
        .mac_clear   (mac_clear),
        .window_end  (window_end)
    );

    layer_execute execute_inst (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .mac_valid   (mac_valid),
        .mac_beat    (mac_beat),
        .mac_clear   (mac_clear),
        .window_end  (window_end),
        .kernel_bus  (kernel_bus),
        .result_idle (result_idle),
        .window_done (window_done),
        .pool_valid  (pool_valid),
        .pool_data   (pool_data)
    );

    layer_result result_inst (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .pool_valid  (pool_valid),
        .pool_data   (pool_data),
        .bias_bus    (bias_bus),
        .result_bus  (result_bus),
        .result_val  (result_val),
        .result_rdy  (result_rdy),
        .result_idle (result_idle)
    );

endmodule

// ==== bench/layers_assertions.sv ====
`timescale 1ns/10ps

module layers_assertions
    import layers_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        image_val,
    input logic        image_rdy,
    input logic        kernel_rdy,
    input result_bus_t result_bus,
    input logic        result_val,
    input logic        result_rdy
);

    int error_count = 0;

    // output holds while the consumer stalls
    result_hold: assert property (@(posedge clk) disable iff (rst)
        result_val && !result_rdy |=> result_val && $stable(result_bus))
    else begin
        error_count++;
        $error("result_bus or result_val changed while result_rdy was low");
    end

    kernel_follow: assert property (@(posedge clk) disable iff (rst)
        image_val && image_rdy |=> kernel_rdy)
    else begin
        error_count++;
        $error("kernel_rdy did not follow an accepted beat");
    end

    // state is UP_RESET one edge into reset
    reset_quiet: assert property (@(posedge clk) rst |=> !image_rdy)
    else begin
        error_count++;
        $error("image_rdy high during reset");
    end

endmodule

bind layers layers_assertions layers_assertions_inst (
    .clk        (clk),
    .rst        (rst),
    .image_val  (image_val),
    .image_rdy  (image_rdy),
    .kernel_rdy (kernel_rdy),
    .result_bus (result_bus),
    .result_val (result_val),
    .result_rdy (result_rdy)
);

// ==== bench/layers_checker.sv ====
`timescale 1ns/10ps

module layers_checker
    import layers_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  result_bus_t result_bus,
    input  logic        result_val,
    input  logic        result_rdy,

    input  logic        expect_val,
    input  result_bus_t expect_data,

    output int          pass_count,
    output int          fail_count,
    output int          pending
);

    result_bus_t expected_q[$];
    result_bus_t want;

    initial begin
        pass_count = 0;
        fail_count = 0;
        pending    = 0;
    end

    // one compare per accepted result, in frame order
    always @(posedge clk) begin
        if (!rst) begin
            if (expect_val) begin
                expected_q.push_back(expect_data);
            end
            if (result_val && result_rdy) begin
                if (expected_q.size() == 0) begin
                    fail_count = fail_count + 1;
                    $display("time %0t: a result came out but no result was expected", $time);
                end else begin
                    want = expected_q.pop_front();
                    if (result_bus !== want) begin
                        fail_count = fail_count + 1;
                        $display("[FAIL] time %0t: got %0d %0d, expected %0d %0d", $time,
                                 $signed(result_bus[1]), $signed(result_bus[0]),
                                 $signed(want[1]), $signed(want[0]));
                    end else begin
                        pass_count = pass_count + 1;
                        $display("result %0d ok: %0d %0d", pass_count + fail_count,
                                 $signed(result_bus[1]), $signed(result_bus[0]));
                    end
                end
            end
            pending = expected_q.size();
        end
    end

endmodule

// ==== bench/layers_tb.sv ====
`timescale 1ns/10ps

module layers_tb
    import layers_pkg::*;
();

    localparam int MAX_WIN       = 4;
    localparam int MAX_BEATS     = 8;
    localparam int RDY_TIMEOUT   = 500;
    localparam int DRAIN_TIMEOUT = 4000;
    localparam int MODE_FULL     = 0;
    localparam int MODE_SMALL    = 1;
    localparam int MODE_NEG      = 2;
    localparam longint PIX_MAX   = (longint'(1) <<< (IMG_WIDTH - 1)) - 1;
    localparam longint PIX_MIN   = -PIX_MAX - 1;

    logic        clk;
    logic        rst;
    cfg_data_t   cfg_data;
    cfg_addr_t   cfg_addr;
    logic        cfg_valid;
    image_beat_t image_bus;
    logic        image_last;
    logic        image_val;
    logic        image_rdy;
    kernel_set_t kernel_bus;
    bias_set_t   bias_bus;
    logic        kernel_rdy;
    result_bus_t result_bus;
    logic        result_val;
    logic        result_rdy;

    logic        expect_val;
    result_bus_t expect_data;
    int          pass_count;
    int          fail_count;
    int          pending;

    image_beat_t win_pix [MAX_WIN][MAX_BEATS];
    kernel_set_t win_ker [MAX_WIN][MAX_BEATS];
    kernel_set_t pend_ker;
    cfg_data_t   cur_word;
    logic        cur_bypass;
    int          cur_pool;
    int          cur_shift;
    int          frames_sent;
    int          seen_before;
    int          fails_before;
    logic        stall_on;
    int          stall_left;

    layers layers_inst (
        .clk        (clk),
        .rst        (rst),
        .cfg_data   (cfg_data),
        .cfg_addr   (cfg_addr),
        .cfg_valid  (cfg_valid),
        .image_bus  (image_bus),
        .image_last (image_last),
        .image_val  (image_val),
        .image_rdy  (image_rdy),
        .kernel_bus (kernel_bus),
        .bias_bus   (bias_bus),
        .kernel_rdy (kernel_rdy),
        .result_bus (result_bus),
        .result_val (result_val),
        .result_rdy (result_rdy)
    );

    layers_checker layers_checker_inst (
        .clk         (clk),
        .rst         (rst),
        .result_bus  (result_bus),
        .result_val  (result_val),
        .result_rdy  (result_rdy),
        .expect_val  (expect_val),
        .expect_data (expect_data),
        .pass_count  (pass_count),
        .fail_count  (fail_count),
        .pending     (pending)
    );

    always #20 clk = ~clk;

    // random stretches of back-pressure on the result port
    always @(negedge clk) begin
        if (!stall_on) begin
            result_rdy = 1'b1;
        end else if (stall_left > 0) begin
            stall_left = stall_left - 1;
        end else begin
            result_rdy = !result_rdy;
            stall_left = $urandom_range(1, 12);
        end
    end

    function automatic longint wrap_acc(input longint value);
        acc_t t;
        t = acc_t'(value);
        return longint'(t);
    endfunction

    // window sums, max pool, bias, relu, shift and saturation
    function automatic result_bus_t expected_result(input int n_win, input int n_beats,
                                                    input bias_set_t bias, input logic bypass,
                                                    input int shift);
        result_bus_t res;
        longint      sum;
        longint      best;
        longint      v;
        best = 0;
        for (int d = 0; d < DEPTH_NB; d++) begin
            for (int w = 0; w < n_win; w++) begin
                sum = 0;
                for (int b = 0; b < n_beats; b++) begin
                    for (int g = 0; g < GROUP_NB; g++) begin
                        sum = sum + longint'($signed(win_pix[w][b].pix[g]))
                                  * longint'($signed(win_ker[w][b].w[d][g]));
                    end
                end
                sum = wrap_acc(sum);
                if (w == 0 || sum > best) begin
                    best = sum;
                end
            end
            v = wrap_acc(best + longint'($signed(bias[d])));
            if (!bypass && v < 0) begin
                v = 0;
            end
            v = v >>> shift;
            if (v > PIX_MAX) begin
                v = PIX_MAX;
            end else if (v < PIX_MIN) begin
                v = PIX_MIN;
            end
            res[d] = pixel_t'(v);
        end
        return res;
    endfunction

    function automatic logic [7:0] draw_value(input int mode, input bit is_pixel);
        case (mode)
            MODE_SMALL: return 8'($urandom_range(0, 7)) - 8'd4;
            // positive pixels against negative weights
            MODE_NEG: begin
                if (is_pixel) begin
                    return 8'(64 + $urandom_range(0, 63));
                end
                return 8'(-64 - int'($urandom_range(0, 64)));
            end
            default: return 8'($urandom);
        endcase
    endfunction

    task automatic stop_on_timeout(input string why);
        $display("timeout: %s", why);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    // weights are only meaningful while kernel_rdy is high
    task automatic drive_kernel();
        if (kernel_rdy) begin
            kernel_bus = pend_ker;
        end else begin
            kernel_bus = kernel_set_t'({$urandom, $urandom});
        end
    endtask

    task automatic wait_image_rdy();
        int waited;
        waited = 0;
        @(negedge clk);
        drive_kernel();
        while (!image_rdy) begin
            waited++;
            if (waited > RDY_TIMEOUT) begin
                stop_on_timeout("image_rdy stayed low between frames");
            end
            @(negedge clk);
            drive_kernel();
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending != 0) begin
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                stop_on_timeout("expected results were never delivered");
            end
            @(negedge clk);
            drive_kernel();
        end
    endtask

    task automatic configure(input int addr, input logic bypass, input int pool, input int shift);
        cfg_data_t word;
        word = '0;
        word[CFG_BYPASS_BIT] = bypass;
        word[CFG_POOL_LSB +: CFG_POOL_WIDTH] = CFG_POOL_WIDTH'(pool);
        word[CFG_SHIFT_LSB +: CFG_SHIFT_WIDTH] = CFG_SHIFT_WIDTH'(shift);
        // results still in flight would see the new fields
        if (addr == CFG_LAYERS_ADDR && word != cur_word) begin
            wait_drain();
        end
        wait_image_rdy();
        cfg_addr  = cfg_addr_t'(addr);
        cfg_data  = word;
        cfg_valid = 1'b1;
        @(negedge clk);
        drive_kernel();
        cfg_valid = 1'b0;
        if (addr == CFG_LAYERS_ADDR) begin
            cur_word   = word;
            cur_bypass = bypass;
            cur_pool   = pool;
            cur_shift  = shift;
        end
    endtask

    task automatic send_window(input int w, input int n_beats);
        int b;
        int waited;
        b = 0;
        while (b < n_beats) begin
            @(negedge clk);
            drive_kernel();
            if ($urandom_range(0, 3) == 0) begin
                image_val = 1'b0;
            end else begin
                image_bus  = win_pix[w][b];
                image_last = (b == n_beats - 1);
                image_val  = 1'b1;
                waited     = 0;
                while (!image_rdy) begin
                    waited++;
                    if (waited > RDY_TIMEOUT) begin
                        stop_on_timeout("image_rdy never rose for a pending beat");
                    end
                    @(negedge clk);
                    drive_kernel();
                end
                pend_ker = win_ker[w][b];
                b++;
            end
        end
    endtask

    task automatic run_frame(input int mode, input int n_beats);
        result_bus_t want;
        wait_image_rdy();
        for (int d = 0; d < DEPTH_NB; d++) begin
            bias_bus[d] = weight_t'($urandom);
        end
        for (int w = 0; w <= cur_pool; w++) begin
            for (int b = 0; b < n_beats; b++) begin
                for (int g = 0; g < GROUP_NB; g++) begin
                    win_pix[w][b].pix[g] = draw_value(mode, 1'b1);
                    for (int d = 0; d < DEPTH_NB; d++) begin
                        win_ker[w][b].w[d][g] = draw_value(mode, 1'b0);
                    end
                end
            end
        end
        want = expected_result(cur_pool + 1, n_beats, bias_bus, cur_bypass, cur_shift);
        for (int w = 0; w <= cur_pool; w++) begin
            send_window(w, n_beats);
        end
        @(negedge clk);
        drive_kernel();
        image_val   = 1'b0;
        image_last  = 1'b0;
        expect_data = want;
        expect_val  = 1'b1;
        @(negedge clk);
        drive_kernel();
        expect_val  = 1'b0;
        frames_sent++;
    endtask

    task automatic report_test(input string name);
        wait_drain();
        $display("test %s: %0d results, %0d mismatches", name,
                 pass_count + fail_count - seen_before, fail_count - fails_before);
        seen_before  = pass_count + fail_count;
        fails_before = fail_count;
    endtask

    initial begin
        void'($urandom(32'hd827e159));
        clk          = 1'b0;
        rst          = 1'b1;
        cfg_data     = '0;
        cfg_addr     = '0;
        cfg_valid    = 1'b0;
        image_bus    = '0;
        image_last   = 1'b0;
        image_val    = 1'b0;
        kernel_bus   = '0;
        bias_bus     = '0;
        result_rdy   = 1'b1;
        expect_val   = 1'b0;
        expect_data  = '0;
        pend_ker     = '0;
        cur_word     = '0;
        cur_bypass   = 1'b0;
        cur_pool     = 0;
        cur_shift    = 0;
        frames_sent  = 0;
        seen_before  = 0;
        fails_before = 0;
        stall_on     = 1'b0;
        stall_left   = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        configure(CFG_LAYERS_ADDR, 1'b1, 0, 0);
        run_frame(MODE_SMALL, 4);
        run_frame(MODE_SMALL, 4);
        report_test("single window");

        // window maxima mostly stay inside the pixel range at this shift
        configure(CFG_LAYERS_ADDR, 1'b1, 3, 8);
        run_frame(MODE_FULL, 6);
        run_frame(MODE_FULL, 6);
        report_test("max pool of four");

        configure(CFG_LAYERS_ADDR, 1'b0, 0, 2);
        run_frame(MODE_NEG, 4);
        run_frame(MODE_NEG, 4);
        configure(CFG_LAYERS_ADDR, 1'b1, 0, 0);
        run_frame(MODE_NEG, 4);
        run_frame(MODE_NEG, 4);
        report_test("negative sums");

        for (int s = 0; s <= 12; s++) begin
            configure(CFG_LAYERS_ADDR, 1'(s % 2), 1, s);
            run_frame(MODE_FULL, 8);
        end
        report_test("shift sweep");

        configure(CFG_LAYERS_ADDR, 1'b1, 1, 6);
        stall_on = 1'b1;
        for (int i = 0; i < 8; i++) begin
            run_frame(MODE_FULL, 5);
        end
        report_test("back-pressure");
        stall_on = 1'b0;

        // a write elsewhere must leave pool 1 and shift 6 in force
        configure(5, 1'b0, 0, 0);
        run_frame(MODE_FULL, 5);
        report_test("other address");

        wait_drain();
        $display("closing: %0d frames, %0d matched, %0d mismatched, %0d assertion failures",
                 frames_sent, pass_count, fail_count,
                 layers_inst.layers_assertions_inst.error_count);
        if (fail_count == 0 && pass_count == frames_sent &&
            layers_inst.layers_assertions_inst.error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
logic/layers_pkg.sv
logic/layer_decode.sv
logic/layer_execute.sv
logic/layer_result.sv
logic/layers.sv
bench/layers_assertions.sv
bench/layers_checker.sv
bench/layers_tb.sv

// ==== Makefile ====
TOP = layers_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
